// File: design/spriteMapPkg.sv
package spriteMapPkg;

  // animation frames shared by both characters, in memory order
  typedef enum logic [2:0]
  {
    frameStill,
    frameWalk1,
    frameWalk2,
    frameWalk3,
    frameJump,
    frameDeath
  } frameT;

  typedef enum logic
  {
    sizeSmall,
    sizeBig
  } sizeT;

  // a load writes one colour index, a fetch only reads
  typedef enum logic
  {
    opFetch,
    opLoad
  } opT;

  // every sprite is 20 pixels wide, the big form is twice as tall
  localparam int spriteWidth = 20;
  localparam int smallHeight = 20;
  localparam int bigHeight = 40;

  localparam int rowWidth = 6;
  localparam int colWidth = 5;

  localparam int smallFrameSize = spriteWidth * smallHeight;
  localparam int bigFrameSize = spriteWidth * bigHeight;

  // six small frames first, then five big frames with no big death frame
  localparam int smallBase = 0;
  localparam int bigBase = 2400;

  localparam int memDepth = 6400;
  localparam int addrWidth = 13;

endpackage

// File: design/colorPkg.sv
package colorPkg;

  typedef enum logic
  {
    charMario,
    charLuigi
  } characterT;

  localparam int indexWidth = 4;

  typedef logic [23:0] rgbT;

  // index 0 of every bitmap is this key colour and is drawn as see-through
  localparam rgbT keyColor = 24'h00FFCC;

  // both palettes hold entries 0 to 6 and only entry 1 differs
  localparam int paletteSize = 7;

  localparam rgbT [0:6] marioPalette = {
    24'h00FFCC,
    24'hF83800,
    24'hEA9A30,
    24'hEF9D34,
    24'h227DBB,
    24'hFFA440,
    24'hAC7C00
  };

  localparam rgbT [0:6] luigiPalette = {
    24'h00FFCC,
    24'h00FF00,
    24'hEA9A30,
    24'hEF9D34,
    24'h227DBB,
    24'hFFA440,
    24'hAC7C00
  };

  // indices past the palette end come out black
  localparam rgbT unusedColor = 24'h000000;

endpackage

// File: design/requestControl.sv
`timescale 1ns/1ns

module requestControl
(
  input  logic                                  clk,
  input  logic                                  rstN,
  input  logic                                  req,
  input  spriteMapPkg::opT                      op,
  input  colorPkg::characterT                   character,
  input  spriteMapPkg::sizeT                    size,
  input  spriteMapPkg::frameT                   frame,
  input  logic [spriteMapPkg::rowWidth-1:0]     row,
  input  logic [spriteMapPkg::colWidth-1:0]     col,
  input  logic [colorPkg::indexWidth-1:0]       loadIndex,
  input  colorPkg::rgbT                         resultColor,
  input  logic                                  resultTransparent,
  input  logic                                  resultValid,
  output logic                                  start,
  output spriteMapPkg::opT                      reqOp,
  output colorPkg::characterT                   reqCharacter,
  output spriteMapPkg::sizeT                    reqSize,
  output spriteMapPkg::frameT                   reqFrame,
  output logic [spriteMapPkg::rowWidth-1:0]     reqRow,
  output logic [spriteMapPkg::colWidth-1:0]     reqCol,
  output logic [colorPkg::indexWidth-1:0]       reqIndex,
  output logic                                  ack,
  output colorPkg::rgbT                         color,
  output logic                                  transparent
);

  typedef enum logic [1:0]
  {
    stIdle,
    stBusy,
    stAck
  } stateT;

  stateT state;

  // a request is accepted only from idle, so at most one is ever in flight
  logic accept;

  assign accept = (state == stIdle) && req;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= stIdle;
      start <= 1'b0;
      ack <= 1'b0;
      color <= colorPkg::keyColor;
      transparent <= 1'b1;
    end
    else
    begin
      start <= accept;
      case (state)
        stIdle:
        begin
          if (req)
          begin
            state <= stBusy;
          end
        end
        stBusy:
        begin
          // the result is frozen here for as long as ack stays high
          if (resultValid)
          begin
            color <= resultColor;
            transparent <= resultTransparent;
            ack <= 1'b1;
            state <= stAck;
          end
        end
        stAck:
        begin
          if (!req)
          begin
            ack <= 1'b0;
            state <= stIdle;
          end
        end
        default:
        begin
          state <= stIdle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      reqOp <= op;
      reqCharacter <= character;
      reqSize <= size;
      reqFrame <= frame;
      reqRow <= row;
      reqCol <= col;
      reqIndex <= loadIndex;
    end
  end

endmodule

// File: design/spriteAddressGen.sv
`timescale 1ns/1ns

module spriteAddressGen
(
  input  logic                                  clk,
  input  logic                                  rstN,
  input  logic                                  start,
  input  spriteMapPkg::opT                      reqOp,
  input  colorPkg::characterT                   reqCharacter,
  input  spriteMapPkg::sizeT                    reqSize,
  input  spriteMapPkg::frameT                   reqFrame,
  input  logic [spriteMapPkg::rowWidth-1:0]     reqRow,
  input  logic [spriteMapPkg::colWidth-1:0]     reqCol,
  input  logic [colorPkg::indexWidth-1:0]       reqIndex,
  output logic [spriteMapPkg::addrWidth-1:0]    addr,
  output logic                                  writeEn,
  output logic [colorPkg::indexWidth-1:0]       writeIndex,
  output logic                                  outside,
  output colorPkg::characterT                   addrCharacter,
  output logic                                  addrValid
);

  typedef logic [spriteMapPkg::addrWidth-1:0] addrT;

  int frameBase;
  int frameHeight;
  logic frameLegal;
  logic isOutside;
  addrT linearAddr;

  always_comb
  begin
    frameLegal = reqFrame <= spriteMapPkg::frameDeath;
    // there is no big death bitmap, so big death falls back to the small one
    if (reqSize == spriteMapPkg::sizeBig && reqFrame != spriteMapPkg::frameDeath)
    begin
      frameBase = spriteMapPkg::bigBase + int'(reqFrame) * spriteMapPkg::bigFrameSize;
      frameHeight = spriteMapPkg::bigHeight;
    end
    else
    begin
      frameBase = spriteMapPkg::smallBase + int'(reqFrame) * spriteMapPkg::smallFrameSize;
      frameHeight = spriteMapPkg::smallHeight;
    end
    isOutside = !frameLegal
      || int'(reqCol) >= spriteMapPkg::spriteWidth
      || int'(reqRow) >= frameHeight;
    // an outside request never writes and its read is masked in the palette stage
    linearAddr = addrT'(frameBase + int'(reqRow) * spriteMapPkg::spriteWidth + int'(reqCol));
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      writeEn <= 1'b0;
      addrValid <= 1'b0;
    end
    else
    begin
      writeEn <= start && (reqOp == spriteMapPkg::opLoad) && !isOutside;
      addrValid <= start;
    end
  end

  always_ff @(posedge clk)
  begin
    addr <= linearAddr;
    writeIndex <= reqIndex;
    outside <= isOutside;
    addrCharacter <= reqCharacter;
  end

endmodule

// File: design/indexMemory.sv
`timescale 1ns/1ns

module indexMemory
(
  input  logic                                  clk,
  input  logic [spriteMapPkg::addrWidth-1:0]    addr,
  input  logic                                  writeEn,
  input  logic [colorPkg::indexWidth-1:0]       writeIndex,
  output logic [colorPkg::indexWidth-1:0]       readIndex
);

  // one 4-bit colour index per pixel of every frame
  logic [colorPkg::indexWidth-1:0] mem [spriteMapPkg::memDepth];

  // single port, a write hands back the new value in the same cycle
  always_ff @(posedge clk)
  begin
    if (writeEn)
    begin
      mem[addr] <= writeIndex;
      readIndex <= writeIndex;
    end
    else
    begin
      readIndex <= mem[addr];
    end
  end

endmodule

// File: design/paletteLookup.sv
`timescale 1ns/1ns

module paletteLookup
(
  input  logic                                  clk,
  input  logic                                  rstN,
  input  logic [colorPkg::indexWidth-1:0]       readIndex,
  input  logic                                  outside,
  input  colorPkg::characterT                   addrCharacter,
  input  logic                                  addrValid,
  output colorPkg::rgbT                         resultColor,
  output logic                                  resultTransparent,
  output logic                                  resultValid
);

  // these ride one cycle behind the address stage to meet readIndex
  logic outsideD;
  colorPkg::characterT characterD;
  logic validD;

  colorPkg::rgbT lookColor;
  logic isClear;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      validD <= 1'b0;
      resultValid <= 1'b0;
    end
    else
    begin
      validD <= addrValid;
      resultValid <= validD;
    end
  end

  always_ff @(posedge clk)
  begin
    outsideD <= outside;
    characterD <= addrCharacter;
  end

  always_comb
  begin
    if (int'(readIndex) >= colorPkg::paletteSize)
    begin
      lookColor = colorPkg::unusedColor;
    end
    else if (characterD == colorPkg::charLuigi)
    begin
      lookColor = colorPkg::luigiPalette[readIndex[2:0]];
    end
    else
    begin
      lookColor = colorPkg::marioPalette[readIndex[2:0]];
    end
    isClear = outsideD || (readIndex == '0);
  end

  always_ff @(posedge clk)
  begin
    resultColor <= isClear ? colorPkg::keyColor : lookColor;
    resultTransparent <= isClear;
  end

endmodule

// File: design/spriteFetch.sv
`timescale 1ns/1ns

module spriteFetch
(
  input  logic                                  clk,
  input  logic                                  rstN,
  input  logic                                  req,
  input  spriteMapPkg::opT                      op,
  input  colorPkg::characterT                   character,
  input  spriteMapPkg::sizeT                    size,
  input  spriteMapPkg::frameT                   frame,
  input  logic [spriteMapPkg::rowWidth-1:0]     row,
  input  logic [spriteMapPkg::colWidth-1:0]     col,
  input  logic [colorPkg::indexWidth-1:0]       loadIndex,
  output logic                                  ack,
  output colorPkg::rgbT                         color,
  output logic                                  transparent
);

  logic start;
  spriteMapPkg::opT reqOp;
  colorPkg::characterT reqCharacter;
  spriteMapPkg::sizeT reqSize;
  spriteMapPkg::frameT reqFrame;
  logic [spriteMapPkg::rowWidth-1:0] reqRow;
  logic [spriteMapPkg::colWidth-1:0] reqCol;
  logic [colorPkg::indexWidth-1:0] reqIndex;

  logic [spriteMapPkg::addrWidth-1:0] addr;
  logic writeEn;
  logic [colorPkg::indexWidth-1:0] writeIndex;
  logic outside;
  colorPkg::characterT addrCharacter;
  logic addrValid;

  logic [colorPkg::indexWidth-1:0] readIndex;

  colorPkg::rgbT resultColor;
  logic resultTransparent;
  logic resultValid;

  requestControl control (.*);

  // address, memory read and palette each take one cycle
  spriteAddressGen addressGen (.*);

  indexMemory memory (
    .clk        (clk),
    .addr       (addr),
    .writeEn    (writeEn),
    .writeIndex (writeIndex),
    .readIndex  (readIndex)
  );

  paletteLookup lookup (.*);

endmodule

// File: verif/spriteFetch_checker.sv
`timescale 1ns/1ns

module spriteFetchChecker
(
  input logic           clk,
  input logic           rstN,
  input logic           req,
  input logic           ack,
  input colorPkg::rgbT  color,
  input logic           transparent
);

  // the first sampled cycle out of reset must see ack low
  ackLowAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !ack)
    else $error("ack was high in the first cycle after reset");

  // ack is raised on an edge where req was sampled high
  ackRiseNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
    $rose(ack) |-> $past(req))
    else $error("ack rose while req was low");

  // ack is dropped on an edge where req was sampled low
  ackFallNeedsNoReq: assert property (@(posedge clk) disable iff (!rstN)
    $fell(ack) |-> !$past(req))
    else $error("ack fell while req was still high");

  // the result is frozen for as long as ack stays high
  resultStableWhileAck: assert property (@(posedge clk) disable iff (!rstN)
    (ack && $past(ack)) |-> ($stable(color) && $stable(transparent)))
    else $error("color or transparent changed while ack was high");

endmodule

bind spriteFetch spriteFetchChecker handshakeCheck (
  .clk         (clk),
  .rstN        (rstN),
  .req         (req),
  .ack         (ack),
  .color       (color),
  .transparent (transparent)
);

// File: verif/spriteFetchTb.sv
`timescale 1ns/1ns

module spriteFetchTb;

  localparam int clkPeriod = 20;
  localparam int driveDelay = 2;
  localparam int resetCycles = 4;
  localparam int cyclesPerTest = 12;
  localparam int maxTests = 64;

  logic clk;
  logic rstN;
  logic req;
  spriteMapPkg::opT op;
  colorPkg::characterT character;
  spriteMapPkg::sizeT size;
  spriteMapPkg::frameT frame;
  logic [spriteMapPkg::rowWidth-1:0] row;
  logic [spriteMapPkg::colWidth-1:0] col;
  logic [colorPkg::indexWidth-1:0] loadIndex;
  logic ack;
  colorPkg::rgbT color;
  logic transparent;

  // one entry per request line of the data file
  logic [8*24-1:0] testName [maxTests];
  spriteMapPkg::opT testOp [maxTests];
  colorPkg::characterT testCharacter [maxTests];
  spriteMapPkg::sizeT testSize [maxTests];
  spriteMapPkg::frameT testFrame [maxTests];
  logic [spriteMapPkg::rowWidth-1:0] testRow [maxTests];
  logic [spriteMapPkg::colWidth-1:0] testCol [maxTests];
  logic [colorPkg::indexWidth-1:0] testIndex [maxTests];
  colorPkg::rgbT testColor [maxTests];
  logic testTransparent [maxTests];

  int testCount;
  logic dataLoaded;
  int colorErrors;
  int transparentErrors;
  int otherErrors;
  logic [31:0] lfsrState;

  spriteFetch dut (.*);

  // taps 32, 22, 2 and 1 give a maximal length sequence
  function automatic logic [31:0] stepLfsr(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  task automatic takeRandomBits(input int count, output int value);
    value = 0;
    for (int i = 0; i < count; i++)
    begin
      lfsrState = stepLfsr(lfsrState);
      value = (value << 1) | int'(lfsrState[0]);
    end
  endtask

  task automatic readTestData();
    int fd;
    int gotChars;
    int fields;
    logic [8*128-1:0] lineBuf;
    logic [8*24-1:0] name;
    int fOp;
    int fChar;
    int fSize;
    int fFrame;
    int fRow;
    int fCol;
    int fIndex;
    int fTrans;
    logic [23:0] fColor;
    fd = $fopen("verif/spriteFetch_testdata.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the test data file");
      otherErrors++;
    end
    else
    begin
      while (!$feof(fd) && testCount < maxTests)
      begin
        lineBuf = '0;
        gotChars = $fgets(lineBuf, fd);
        fields = $sscanf(lineBuf, "%s %d %d %d %d %d %d %d %h %d", name, fOp, fChar,
          fSize, fFrame, fRow, fCol, fIndex, fColor, fTrans);
        // comment and blank lines never fill all ten columns
        if (gotChars > 0 && fields == 10)
        begin
          testName[testCount] = name;
          testOp[testCount] = spriteMapPkg::opT'(fOp[0]);
          testCharacter[testCount] = colorPkg::characterT'(fChar[0]);
          testSize[testCount] = spriteMapPkg::sizeT'(fSize[0]);
          testFrame[testCount] = spriteMapPkg::frameT'(fFrame[2:0]);
          testRow[testCount] = fRow[spriteMapPkg::rowWidth-1:0];
          testCol[testCount] = fCol[spriteMapPkg::colWidth-1:0];
          testIndex[testCount] = fIndex[colorPkg::indexWidth-1:0];
          testColor[testCount] = fColor;
          testTransparent[testCount] = fTrans[0];
          testCount++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic checkResult(input int t);
    assert (color == testColor[t]) else
    begin
      $display("mismatch %0s color expected %06h actual %06h",
        testName[t], testColor[t], color);
      colorErrors++;
    end
    assert (transparent == testTransparent[t]) else
    begin
      $display("mismatch %0s transparent expected %0d actual %0d",
        testName[t], testTransparent[t], transparent);
      transparentErrors++;
    end
  endtask

  task automatic waitCycle();
    @(posedge clk);
    #driveDelay;
  endtask

  // one full four-phase handshake, entered and left just after a clock edge
  task automatic runRequest(input int t);
    int holdCycles;
    takeRandomBits(2, holdCycles);
    op = testOp[t];
    character = testCharacter[t];
    size = testSize[t];
    frame = testFrame[t];
    row = testRow[t];
    col = testCol[t];
    loadIndex = testIndex[t];
    req = 1'b1;
    do
    begin
      waitCycle();
    end
    while (!ack);
    checkResult(t);
    // back-pressure, the requester keeps req high a little longer
    if (holdCycles > 0)
    begin
      repeat (holdCycles) waitCycle();
      checkResult(t);
    end
    req = 1'b0;
    do
    begin
      waitCycle();
    end
    while (ack);
  endtask

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial
  begin
    wait (dataLoaded);
    repeat (resetCycles + 2 + testCount * cyclesPerTest) @(posedge clk);
    $display("timeout, the request handshake never completed");
    $display("Finished with errors");
    $finish;
  end

  initial
  begin
    dataLoaded = 1'b0;
    rstN = 1'b0;
    req = 1'b0;
    op = spriteMapPkg::opFetch;
    character = colorPkg::charMario;
    size = spriteMapPkg::sizeSmall;
    frame = spriteMapPkg::frameStill;
    row = '0;
    col = '0;
    loadIndex = '0;
    lfsrState = 32'h83ec9e9c;
    testCount = 0;
    colorErrors = 0;
    transparentErrors = 0;
    otherErrors = 0;
    readTestData();
    if (testCount == 0)
    begin
      $display("the test data file held no request lines");
      otherErrors++;
    end
    dataLoaded = 1'b1;
    repeat (resetCycles) @(posedge clk);
    #driveDelay;
    rstN = 1'b1;
    assert (!ack && color == colorPkg::keyColor && transparent) else
    begin
      $display("outputs were not at their reset values after reset");
      otherErrors++;
    end
    for (int t = 0; t < testCount; t++)
    begin
      runRequest(t);
    end
    $display("errors: color %0d, transparent %0d, other %0d",
      colorErrors, transparentErrors, otherErrors);
    if (colorErrors + transparentErrors + otherErrors == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: verif/spriteFetch_testdata.txt
# name op char size frame row col loadIndex expColor expTransparent
# op 1 is load, char 1 is luigi, size 1 is big, frame 0 to 5 is still to death, colour in hex
loadStill 1 0 0 0 3 7 1 F83800 0
loadWalk1 1 0 0 1 3 7 2 EA9A30 0
loadWalk2 1 0 0 2 3 7 3 EF9D34 0
loadWalk3 1 0 0 3 3 7 4 227DBB 0
loadJump 1 0 0 4 3 7 5 FFA440 0
loadDeath 1 0 0 5 3 7 6 AC7C00 0
fetchStill 0 0 0 0 3 7 0 F83800 0
fetchWalk1 0 0 0 1 3 7 0 EA9A30 0
fetchWalk2 0 0 0 2 3 7 0 EF9D34 0
fetchWalk3 0 0 0 3 3 7 0 227DBB 0
fetchJump 0 0 0 4 3 7 0 FFA440 0
fetchDeath 0 0 0 5 3 7 0 AC7C00 0
fetchStillLuigi 0 1 0 0 3 7 0 00FF00 0
fetchWalk1Luigi 0 1 0 1 3 7 0 EA9A30 0
fetchJumpLuigi 0 1 0 4 3 7 0 FFA440 0
loadBigStillBottom 1 0 1 0 39 19 4 227DBB 0
loadBigWalk2Row25 1 1 1 2 25 0 1 00FF00 0
fetchBigStillBottom 0 1 1 0 39 19 0 227DBB 0
fetchBigWalk2Row25 0 0 1 2 25 0 0 F83800 0
fetchBigDeath 0 1 1 5 3 7 0 AC7C00 0
fetchBigDeathRow25 0 0 1 5 25 0 0 00FFCC 1
fetchBigRow40 0 0 1 0 40 0 0 00FFCC 1
loadIndex0 1 0 0 0 10 10 0 00FFCC 1
fetchIndex0 0 1 0 0 10 10 0 00FFCC 1
loadIndex7 1 0 0 0 10 11 7 000000 0
fetchIndex7 0 1 0 0 10 11 0 000000 0
loadIndex15 1 1 0 0 10 12 15 000000 0
fetchIndex15 0 0 0 0 10 12 0 000000 0
loadAliasTarget 1 0 0 0 1 5 3 EF9D34 0
loadColOut 1 0 0 0 0 25 5 00FFCC 1
fetchAliasTarget 0 0 0 0 1 5 0 EF9D34 0
loadWalk1Origin 1 1 0 1 0 0 2 EA9A30 0
loadRowOut 1 0 0 0 20 0 6 00FFCC 1
fetchWalk1Origin 0 0 0 1 0 0 0 EA9A30 0
fetchCol31 0 0 0 3 5 31 0 00FFCC 1
fetchRow63 0 1 1 4 63 19 0 00FFCC 1

// File: spriteFetch.f
design/spriteMapPkg.sv
design/colorPkg.sv
design/requestControl.sv
design/spriteAddressGen.sv
design/indexMemory.sv
design/paletteLookup.sv
design/spriteFetch.sv
verif/spriteFetch_checker.sv
verif/spriteFetchTb.sv

// File: run.sh
#!/bin/sh
# compiles the spriteFetch testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module spriteFetchTb \
  -f spriteFetch.f -o spriteFetchSim

simOutput=$(./obj_dir/spriteFetchSim 2>&1) || true
echo "$simOutput"

if echo "$simOutput" | grep -qx "Finished with no errors"
then
  exit 0
fi
exit 1
